// File: Makefile
# Verilator build and run of the quadrant testbench.

TOP := tb_quadrant

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass line"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

# The exit status is that of grep, so a missing pass line fails the target.
test:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

// File: compile.f
verilog/quadrant_pkg.sv
verilog/quadrant_addr_decode.sv
verilog/cluster_tile.sv
verilog/quadrant_resp_merge.sv
verilog/quadrant_top.sv
verif/quadrant_checker.sv
verif/tb_quadrant.sv

// File: verif/quadrant_checker.sv
// Quadrant response checker.
// Watches the AXI4-Lite B and R channels and compares each accepted response
// with the next expected one queued by the testbench. A response held under
// back-pressure must keep its value until it is accepted, and no request
// channel may be ready while a response is pending.

module quadrant_checker (
  input logic                               clk_i,
  input logic                               rst_n_i,
  input logic                               awready_i,
  input logic                               wready_i,
  input logic                               arready_i,
  input logic                               bvalid_i,
  input logic                               bready_i,
  input quadrant_pkg::axi_resp_e            bresp_i,
  input logic                               rvalid_i,
  input logic                               rready_i,
  input logic [quadrant_pkg::DataWidth-1:0] rdata_i,
  input quadrant_pkg::axi_resp_e            rresp_i
);

  timeunit 1ns;
  timeprecision 100ps;

  import quadrant_pkg::*;

  axi_resp_e            bresp_q [$];
  axi_resp_e            rresp_q [$];
  logic [DataWidth-1:0] rdata_q [$];
  int unsigned          errors = 0;
  int unsigned          checks = 0;
  logic                 b_held = 1'b0;
  logic                 r_held = 1'b0;
  axi_resp_e            b_held_resp;
  axi_resp_e            r_held_resp;
  logic [DataWidth-1:0] r_held_data;
  axi_resp_e            exp_resp;
  logic [DataWidth-1:0] exp_data;

  function automatic void push_write_resp(input axi_resp_e resp);
    bresp_q.push_back(resp);
  endfunction

  function automatic void push_read_resp(input logic [DataWidth-1:0] data,
                                         input axi_resp_e resp);
    rdata_q.push_back(data);
    rresp_q.push_back(resp);
  endfunction

  // Anything left here never got its response.
  function automatic void check_drained();
    if (bresp_q.size() != 0 || rresp_q.size() != 0) begin
      $display("Responses missing: %0d writes and %0d reads were never answered",
               bresp_q.size(), rresp_q.size());
      errors++;
    end
  endfunction

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      b_held = 1'b0;
      r_held = 1'b0;
    end else begin
      // No new request may be accepted while a response is pending.
      if ((bvalid_i || rvalid_i) && (awready_i || wready_i || arready_i)) begin
        $display("Error t=%0t: awready/wready/arready expected 000 got %b%b%b", $time,
                 awready_i, wready_i, arready_i);
        errors++;
      end

      // Held responses must not change or drop.
      if (b_held && !bvalid_i) begin
        $display("Write response dropped before it was accepted at %0t", $time);
        errors++;
      end else if (b_held && bresp_i !== b_held_resp) begin
        $display("Error t=%0t: bresp (held) expected %s got %s", $time,
                 b_held_resp.name(), bresp_i.name());
        errors++;
      end
      if (r_held && !rvalid_i) begin
        $display("Read response dropped before it was accepted at %0t", $time);
        errors++;
      end else if (r_held) begin
        if (rdata_i !== r_held_data) begin
          $display("Error t=%0t: rdata (held) expected %h got %h", $time, r_held_data,
                   rdata_i);
          errors++;
        end
        if (rresp_i !== r_held_resp) begin
          $display("Error t=%0t: rresp (held) expected %s got %s", $time,
                   r_held_resp.name(), rresp_i.name());
          errors++;
        end
      end

      if (bvalid_i && bready_i) begin
        if (bresp_q.size() == 0) begin
          $display("Write response at %0t arrived with nothing expected", $time);
          errors++;
        end else begin
          exp_resp = bresp_q.pop_front();
          checks++;
          if (bresp_i !== exp_resp) begin
            $display("Error t=%0t: bresp expected %s got %s", $time,
                     exp_resp.name(), bresp_i.name());
            errors++;
          end
        end
      end

      if (rvalid_i && rready_i) begin
        if (rresp_q.size() == 0) begin
          $display("Read response at %0t arrived with nothing expected", $time);
          errors++;
        end else begin
          exp_resp = rresp_q.pop_front();
          exp_data = rdata_q.pop_front();
          checks++;
          if (rresp_i !== exp_resp) begin
            $display("Error t=%0t: rresp expected %s got %s", $time,
                     exp_resp.name(), rresp_i.name());
            errors++;
          end
          if (rdata_i !== exp_data) begin
            $display("Error t=%0t: rdata expected %h got %h", $time, exp_data, rdata_i);
            errors++;
          end
        end
      end

      b_held      = bvalid_i && !bready_i;
      b_held_resp = bresp_i;
      r_held      = rvalid_i && !rready_i;
      r_held_resp = rresp_i;
      r_held_data = rdata_i;
    end
  end

endmodule

// File: verif/tb_quadrant.sv
// Quadrant testbench.
// Seeded random AXI4-Lite traffic against a word-level memory model.
// Expected responses go to the checker, which compares the B and R channels.

module tb_quadrant;

  timeunit 1ns;
  timeprecision 100ps;

  import quadrant_pkg::*;

  localparam int unsigned NrClusters      = 4;
  localparam int unsigned WordsPerCluster = 16;
  localparam int unsigned ClusterSpace    = WordsPerCluster * 4;
  localparam tile_id_t    TileId          = 4'd3;
  localparam int unsigned NumWr           = 24;
  localparam int unsigned NumStrb         = 12;
  localparam int unsigned NumDec          = 12;
  localparam int unsigned NumMix          = 40;
  localparam int unsigned TotalTxns       = 2 * NumWr + 2 * NumStrb + 3 * NrClusters +
                                            NumDec + 4 + NumMix;

  logic                 clk;
  logic                 rst_n;
  logic                 awvalid, awready, wvalid, wready, bvalid, bready;
  logic                 arvalid, arready, rvalid, rready;
  logic [AddrWidth-1:0] awaddr, araddr;
  logic [DataWidth-1:0] wdata, rdata;
  logic [StrbWidth-1:0] wstrb;
  axi_resp_e            bresp, rresp;

  // Words present in the map are known.
  logic [DataWidth-1:0] model_mem [logic [AddrWidth-1:0]];
  logic [AddrWidth-1:0] written_q [$];
  int unsigned          err_mark = 0;
  int unsigned          test_count = 0;

  quadrant_top #(
    .NrClusters      (NrClusters),
    .WordsPerCluster (WordsPerCluster)
  ) i_quadrant_top (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .tile_id_i (TileId),
    .awvalid_i (awvalid),
    .awready_o (awready),
    .awaddr_i  (awaddr),
    .wvalid_i  (wvalid),
    .wready_o  (wready),
    .wdata_i   (wdata),
    .wstrb_i   (wstrb),
    .bvalid_o  (bvalid),
    .bready_i  (bready),
    .bresp_o   (bresp),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .araddr_i  (araddr),
    .rvalid_o  (rvalid),
    .rready_i  (rready),
    .rdata_o   (rdata),
    .rresp_o   (rresp)
  );

  quadrant_checker i_quadrant_checker (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .awready_i (awready),
    .wready_i  (wready),
    .arready_i (arready),
    .bvalid_i  (bvalid),
    .bready_i  (bready),
    .bresp_i   (bresp),
    .rvalid_i  (rvalid),
    .rready_i  (rready),
    .rdata_i   (rdata),
    .rresp_i   (rresp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Base address of cluster idx in this tile.
  function automatic logic [AddrWidth-1:0] cluster_base(input int unsigned idx);
    return ClusterBaseOffset + AddrWidth'((TileId * NrClusters + idx) * ClusterSpace);
  endfunction

  function automatic logic [DataWidth-1:0] hart_base(input int unsigned idx);
    return DataWidth'(TileId * NrClusters * NrCoresCluster + idx * NrCoresCluster);
  endfunction

  function automatic int find_cluster(input logic [AddrWidth-1:0] addr);
    for (int i = 0; i < NrClusters; i++) begin
      if (addr >= cluster_base(i) && addr < cluster_base(i) + ClusterSpace) begin
        return i;
      end
    end
    return -1;
  endfunction

  function automatic logic [AddrWidth-1:0] random_word();
    return cluster_base($urandom_range(0, NrClusters - 1)) +
           AddrWidth'(4 * $urandom_range(1, WordsPerCluster - 1));
  endfunction

  function automatic logic [AddrWidth-1:0] known_word();
    return written_q[$urandom_range(0, written_q.size() - 1)];
  endfunction

  // Applies a write to the model and returns its response.
  function automatic axi_resp_e predict_write(input logic [AddrWidth-1:0] addr,
                                              input logic [DataWidth-1:0] data,
                                              input logic [StrbWidth-1:0] strb);
    int                   c;
    logic [DataWidth-1:0] word;
    c = find_cluster(addr);
    if (c < 0) begin
      return DECERR;
    end
    if (addr - cluster_base(c) < 4) begin
      return SLVERR;
    end
    word = '0;
    if (model_mem.exists(addr)) begin
      word = model_mem[addr];
    end
    for (int b = 0; b < StrbWidth; b++) begin
      if (strb[b]) begin
        word[8*b +: 8] = data[8*b +: 8];
      end
    end
    model_mem[addr] = word;
    return OKAY;
  endfunction

  function automatic void predict_read(input logic [AddrWidth-1:0] addr,
                                       output logic [DataWidth-1:0] data,
                                       output axi_resp_e resp);
    int c;
    c = find_cluster(addr);
    data = '0;
    resp = OKAY;
    if (c < 0) begin
      resp = DECERR;
    end else if (addr - cluster_base(c) < 4) begin
      data = hart_base(c);
    end else if (model_mem.exists(addr)) begin
      data = model_mem[addr];
    end else begin
      $display("Testbench read an unwritten word at %h", addr);
      i_quadrant_checker.errors++;
    end
  endfunction

  // Ready is held low for a random stretch, then waits for the handshake.
  task automatic collect_response(input bit is_write);
    int unsigned stall;
    bit          done;
    stall = $urandom_range(0, 8);
    done = 1'b0;
    while (!done) begin
      if (stall == 0) begin
        bready = is_write;
        rready = !is_write;
      end else begin
        stall--;
      end
      @(negedge clk);
      done = is_write ? (bvalid && bready) : (rvalid && rready);
      @(posedge clk);
      #2;
    end
    bready = 1'b0;
    rready = 1'b0;
  endtask

  task automatic send_write(input logic [AddrWidth-1:0] addr,
                            input logic [DataWidth-1:0] data,
                            input logic [StrbWidth-1:0] strb);
    bit done;
    i_quadrant_checker.push_write_resp(predict_write(addr, data, strb));
    awaddr = addr;
    wdata = data;
    wstrb = strb;
    awvalid = 1'b1;
    wvalid = 1'b1;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = awready && wready;
      @(posedge clk);
      #2;
    end
    awvalid = 1'b0;
    wvalid = 1'b0;
    collect_response(1'b1);
  endtask

  task automatic fetch_read(input logic [AddrWidth-1:0] addr);
    logic [DataWidth-1:0] data;
    axi_resp_e            resp;
    bit                   done;
    predict_read(addr, data, resp);
    i_quadrant_checker.push_read_resp(data, resp);
    araddr = addr;
    arvalid = 1'b1;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = arready;
      @(posedge clk);
      #2;
    end
    arvalid = 1'b0;
    collect_response(1'b0);
  endtask

  task automatic report_test(input string name);
    int unsigned now;
    now = i_quadrant_checker.errors;
    $display("Test %-16s %s (%0d errors)", name, (now == err_mark) ? "ok" : "failed",
             now - err_mark);
    err_mark = now;
    test_count++;
  endtask

  initial begin
    int unsigned          kind;
    int unsigned          total_err;
    logic [AddrWidth-1:0] addr;
    void'($urandom(32'h6c07));
    rst_n = 1'b0;
    awvalid = 1'b0;
    wvalid = 1'b0;
    arvalid = 1'b0;
    bready = 1'b0;
    rready = 1'b0;
    awaddr = '0;
    araddr = '0;
    wdata = '0;
    wstrb = '0;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;

    for (int n = 0; n < NumWr; n++) begin
      addr = random_word();
      written_q.push_back(addr);
      send_write(addr, $urandom(), '1);
    end
    for (int n = 0; n < NumWr; n++) begin
      fetch_read(written_q[n]);
    end
    report_test("write_readback");

    for (int n = 0; n < NumStrb; n++) begin
      addr = known_word();
      send_write(addr, $urandom(), StrbWidth'($urandom_range(1, 14)));
      fetch_read(addr);
    end
    report_test("byte_strobes");

    for (int c = 0; c < NrClusters; c++) begin
      fetch_read(cluster_base(c));
      send_write(cluster_base(c), $urandom(), '1);
      fetch_read(cluster_base(c));
    end
    report_test("identity_word");

    // Below the window, above it, and inside the lower neighbor tile.
    for (int n = 0; n < NumDec; n++) begin
      case (n % 3)
        0: addr = AddrWidth'($urandom_range(0, ClusterBaseOffset - 1));
        1: addr = cluster_base(NrClusters - 1) + ClusterSpace +
                  AddrWidth'($urandom_range(0, 16'hffff));
        default: addr = cluster_base(0) - AddrWidth'(NrClusters * ClusterSpace) +
                        AddrWidth'($urandom_range(0, NrClusters * ClusterSpace - 1));
      endcase
      addr[1:0] = 2'b00;
      if ($urandom_range(0, 1) == 1) begin
        send_write(addr, $urandom(), '1);
      end else begin
        fetch_read(addr);
      end
    end
    for (int n = 0; n < 4; n++) begin
      fetch_read(known_word());
    end
    report_test("decode_errors");

    for (int n = 0; n < NumMix; n++) begin
      kind = $urandom_range(0, 4);
      if (kind < 2) begin
        fetch_read(known_word());
      end else if (kind == 2) begin
        addr = random_word();
        written_q.push_back(addr);
        send_write(addr, $urandom(), '1);
      end else if (kind == 3) begin
        send_write(known_word(), $urandom(), StrbWidth'($urandom_range(0, 15)));
      end else begin
        fetch_read(cluster_base($urandom_range(0, NrClusters - 1)));
      end
    end
    report_test("backpressure_mix");

    i_quadrant_checker.check_drained();
    total_err = i_quadrant_checker.errors;
    $display("Summary: %0d tests, %0d responses checked, %0d errors", test_count,
             i_quadrant_checker.checks, total_err);
    if (total_err == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Each transaction gets 60 cycles at most.
  initial begin
    repeat (16 + 60 * TotalTxns) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", 16 + 60 * TotalTxns);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: verilog/cluster_tile.sv
// Cluster tile.
// Small scratchpad with byte strobes. Word 0 is a read-only identity word
// holding the hart base id of this cluster. Every request is answered
// exactly one cycle later.

module cluster_tile #(
  parameter int unsigned WordsPerCluster = 16,
  parameter int unsigned ClusterIdx      = 0,
  parameter int unsigned NrClusters      = 4
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  quadrant_pkg::tile_id_t             tile_id_i,
  input  logic                               req_valid_i,
  input  logic                               req_we_i,
  input  logic [$clog2(WordsPerCluster)-1:0] req_word_i,
  input  logic [quadrant_pkg::DataWidth-1:0] req_wdata_i,
  input  logic [quadrant_pkg::StrbWidth-1:0] req_wstrb_i,
  output logic                               rsp_valid_o,
  output logic                               rsp_slverr_o,
  output logic [quadrant_pkg::DataWidth-1:0] rsp_rdata_o
);

  import quadrant_pkg::*;

  logic [DataWidth-1:0] mem_q [WordsPerCluster];
  logic [DataWidth-1:0] hart_base_id;
  logic                 id_word;
  logic                 rsp_valid_q;
  logic                 rsp_slverr_q;
  logic [DataWidth-1:0] rsp_rdata_q;

  // First hart of this cluster within the whole system.
  assign hart_base_id = DataWidth'(tile_id_i) * NrClusters * NrCoresCluster +
                        ClusterIdx * NrCoresCluster;

  assign id_word = (req_word_i == '0);

  // Byte-wise writes. Word 0 is never stored.
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_we_i && !id_word) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (req_wstrb_i[b]) begin
          mem_q[req_word_i][8*b +: 8] <= req_wdata_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i;
    end
  end

  // Response payload is captured with each request.
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rsp_slverr_q <= req_we_i && id_word;
      if (req_we_i) begin
        rsp_rdata_q <= '0;
      end else if (id_word) begin
        rsp_rdata_q <= hart_base_id;
      end else begin
        rsp_rdata_q <= mem_q[req_word_i];
      end
    end
  end

  assign rsp_valid_o  = rsp_valid_q;
  assign rsp_slverr_o = rsp_slverr_q;
  assign rsp_rdata_o  = rsp_rdata_q;

endmodule

// File: verilog/quadrant_addr_decode.sv
// Quadrant address decoder.
// Accepts one AXI4-Lite read or write at a time, builds the cluster address
// map from the tile id and forwards the request to the one matching cluster.
// Addresses outside every cluster window are flagged as a decode error.

module quadrant_addr_decode #(
  parameter int unsigned NrClusters      = 4,
  parameter int unsigned WordsPerCluster = 16
) (
  input  logic                                           clk_i,
  input  logic                                           rst_n_i,
  input  quadrant_pkg::tile_id_t                         tile_id_i,
  input  logic                                           awvalid_i,
  output logic                                           awready_o,
  input  logic [quadrant_pkg::AddrWidth-1:0]             awaddr_i,
  input  logic                                           wvalid_i,
  output logic                                           wready_o,
  input  logic [quadrant_pkg::DataWidth-1:0]             wdata_i,
  input  logic [quadrant_pkg::StrbWidth-1:0]             wstrb_i,
  input  logic                                           arvalid_i,
  output logic                                           arready_o,
  input  logic [quadrant_pkg::AddrWidth-1:0]             araddr_i,
  input  logic                                           resp_done_i,
  output logic [NrClusters-1:0]                          clu_req_valid_o,
  output logic                                           clu_req_we_o,
  output logic [$clog2(WordsPerCluster)-1:0]             clu_req_word_o,
  output logic [quadrant_pkg::DataWidth-1:0]             clu_req_wdata_o,
  output logic [quadrant_pkg::StrbWidth-1:0]             clu_req_wstrb_o,
  output logic                                           dec_err_valid_o,
  output logic                                           req_is_write_o
);

  import quadrant_pkg::*;

  localparam int unsigned WordIdxW = $clog2(WordsPerCluster);
  localparam logic [AddrWidth-1:0] ClusterSpace = AddrWidth'(WordsPerCluster * 4);

  dec_state_e state_q, state_d;

  logic [AddrWidth-1:0]  addr_q;
  logic [DataWidth-1:0]  wdata_q;
  logic [StrbWidth-1:0]  wstrb_q;
  logic                  we_q;
  logic                  ar_accept;
  logic                  aw_accept;
  logic [NrClusters-1:0] hit;

  // Reads win over writes when both are pending.
  assign arready_o = (state_q == IDLE);
  assign awready_o = (state_q == IDLE) && !arvalid_i;
  assign wready_o  = awready_o;

  assign ar_accept = arvalid_i && arready_o;
  assign aw_accept = awvalid_i && wvalid_i && awready_o;

  // Cluster windows follow the tile id.
  for (genvar i = 0; i < NrClusters; i++) begin : gen_window
    logic [AddrWidth-1:0] base;
    assign base = ClusterBaseOffset +
                  (AddrWidth'(tile_id_i) * NrClusters + i) * ClusterSpace;
    assign hit[i] = (addr_q >= base) && (addr_q < base + ClusterSpace);
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (ar_accept || aw_accept) state_d = ISSUE;
      ISSUE:   state_d = WAIT;
      WAIT:    if (resp_done_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      we_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (ar_accept) begin
        we_q <= 1'b0;
      end else if (aw_accept) begin
        we_q <= 1'b1;
      end
    end
  end

  // Request payload.
  always_ff @(posedge clk_i) begin
    if (ar_accept) begin
      addr_q  <= araddr_i;
      wdata_q <= '0;
      wstrb_q <= '0;
    end else if (aw_accept) begin
      addr_q  <= awaddr_i;
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
    end
  end

  // Windows are disjoint, so hit is one-hot or empty.
  assign clu_req_valid_o = (state_q == ISSUE) ? hit : '0;
  assign dec_err_valid_o = (state_q == ISSUE) && (hit == '0);

  // Windows are aligned to their size.
  assign clu_req_word_o  = addr_q[2 +: WordIdxW];
  assign clu_req_we_o    = we_q;
  assign clu_req_wdata_o = wdata_q;
  assign clu_req_wstrb_o = wstrb_q;
  assign req_is_write_o  = we_q;

  a_req_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(clu_req_valid_o));

endmodule

// File: verilog/quadrant_pkg.sv
// Quadrant package.
// Shared widths, the cluster address base, the tile identifier type and
// the AXI4-Lite response and decoder state encodings for the quadrant.

package quadrant_pkg;

  // Bus widths of the AXI4-Lite slave port.
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // First cluster of tile 0 starts here.
  localparam logic [AddrWidth-1:0] ClusterBaseOffset = 32'h1000_0000;

  // Harts accounted for by each cluster in its hart base id.
  localparam int unsigned NrCoresCluster = 2;

  // Tile identifier of the quadrant.
  typedef logic [3:0] tile_id_t;

  // AXI response codes.
  // EXOKAY is never returned by this slave.
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // Request side FSM of the address decoder.
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    ISSUE = 2'd1,
    WAIT  = 2'd2
  } dec_state_e;

endpackage

// File: verilog/quadrant_resp_merge.sv
// Quadrant response merger.
// Picks the one answering cluster, or a decode error, and holds the
// result on the AXI4-Lite B or R channel until the master accepts it.

module quadrant_resp_merge #(
  parameter int unsigned NrClusters = 4
) (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,
  input  logic [NrClusters-1:0]                             clu_rsp_valid_i,
  input  logic [NrClusters-1:0]                             clu_rsp_slverr_i,
  input  logic [NrClusters-1:0][quadrant_pkg::DataWidth-1:0] clu_rsp_rdata_i,
  input  logic                                              dec_err_valid_i,
  input  logic                                              req_is_write_i,
  output logic                                              bvalid_o,
  input  logic                                              bready_i,
  output quadrant_pkg::axi_resp_e                           bresp_o,
  output logic                                              rvalid_o,
  input  logic                                              rready_i,
  output logic [quadrant_pkg::DataWidth-1:0]                rdata_o,
  output quadrant_pkg::axi_resp_e                           rresp_o,
  output logic                                              resp_done_o
);

  import quadrant_pkg::*;

  logic [DataWidth-1:0] sel_rdata;
  logic                 sel_slverr;
  logic                 rsp_in;
  axi_resp_e            resp_code;
  logic                 bvalid_q, rvalid_q;
  axi_resp_e            bresp_q, rresp_q;
  logic [DataWidth-1:0] rdata_q;

  always_comb begin
    sel_rdata  = '0;
    sel_slverr = 1'b0;
    for (int i = 0; i < NrClusters; i++) begin
      if (clu_rsp_valid_i[i]) begin
        sel_rdata  = clu_rsp_rdata_i[i];
        sel_slverr = clu_rsp_slverr_i[i];
      end
    end
  end

  assign rsp_in    = (|clu_rsp_valid_i) || dec_err_valid_i;
  assign resp_code = dec_err_valid_i ? DECERR : (sel_slverr ? SLVERR : OKAY);

  // Only one transaction is in flight, so a new response never meets a pending one.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (rsp_in && req_is_write_i) begin
        bvalid_q <= 1'b1;
      end else if (bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (rsp_in && !req_is_write_i) begin
        rvalid_q <= 1'b1;
      end else if (rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_in && req_is_write_i) begin
      bresp_q <= resp_code;
    end
    if (rsp_in && !req_is_write_i) begin
      rresp_q <= resp_code;
      rdata_q <= dec_err_valid_i ? '0 : sel_rdata;
    end
  end

  assign bvalid_o    = bvalid_q;
  assign bresp_o     = bresp_q;
  assign rvalid_o    = rvalid_q;
  assign rresp_o     = rresp_q;
  assign rdata_o     = rdata_q;
  assign resp_done_o = (bvalid_q && bready_i) || (rvalid_q && rready_i);

  a_rsp_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(clu_rsp_valid_i));

  // The decoder never sends to a cluster and flags an error for the same request.
  a_rsp_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !((|clu_rsp_valid_i) && dec_err_valid_i));

  a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o));

endmodule

// File: verilog/quadrant_top.sv
// Quadrant top level.
// One AXI4-Lite slave port is decoded onto NrClusters cluster tiles and
// the single answer is merged back onto the B or R channel.

module quadrant_top #(
  parameter int unsigned NrClusters      = 4,
  parameter int unsigned WordsPerCluster = 16
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  quadrant_pkg::tile_id_t             tile_id_i,
  input  logic                               awvalid_i,
  output logic                               awready_o,
  input  logic [quadrant_pkg::AddrWidth-1:0] awaddr_i,
  input  logic                               wvalid_i,
  output logic                               wready_o,
  input  logic [quadrant_pkg::DataWidth-1:0] wdata_i,
  input  logic [quadrant_pkg::StrbWidth-1:0] wstrb_i,
  output logic                               bvalid_o,
  input  logic                               bready_i,
  output quadrant_pkg::axi_resp_e            bresp_o,
  input  logic                               arvalid_i,
  output logic                               arready_o,
  input  logic [quadrant_pkg::AddrWidth-1:0] araddr_i,
  output logic                               rvalid_o,
  input  logic                               rready_i,
  output logic [quadrant_pkg::DataWidth-1:0] rdata_o,
  output quadrant_pkg::axi_resp_e            rresp_o
);

  import quadrant_pkg::*;

  localparam int unsigned WordIdxW = $clog2(WordsPerCluster);

  logic [NrClusters-1:0]                clu_req_valid;
  logic                                 clu_req_we;
  logic [WordIdxW-1:0]                  clu_req_word;
  logic [DataWidth-1:0]                 clu_req_wdata;
  logic [StrbWidth-1:0]                 clu_req_wstrb;
  logic [NrClusters-1:0]                clu_rsp_valid;
  logic [NrClusters-1:0]                clu_rsp_slverr;
  logic [NrClusters-1:0][DataWidth-1:0] clu_rsp_rdata;
  logic                                 dec_err_valid;
  logic                                 req_is_write;
  logic                                 resp_done;

  quadrant_addr_decode #(
    .NrClusters      (NrClusters),
    .WordsPerCluster (WordsPerCluster)
  ) i_quadrant_addr_decode (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .tile_id_i       (tile_id_i),
    .awvalid_i       (awvalid_i),
    .awready_o       (awready_o),
    .awaddr_i        (awaddr_i),
    .wvalid_i        (wvalid_i),
    .wready_o        (wready_o),
    .wdata_i         (wdata_i),
    .wstrb_i         (wstrb_i),
    .arvalid_i       (arvalid_i),
    .arready_o       (arready_o),
    .araddr_i        (araddr_i),
    .resp_done_i     (resp_done),
    .clu_req_valid_o (clu_req_valid),
    .clu_req_we_o    (clu_req_we),
    .clu_req_word_o  (clu_req_word),
    .clu_req_wdata_o (clu_req_wdata),
    .clu_req_wstrb_o (clu_req_wstrb),
    .dec_err_valid_o (dec_err_valid),
    .req_is_write_o  (req_is_write)
  );

  // One tile per cluster. Each knows its own index.
  for (genvar i = 0; i < NrClusters; i++) begin : gen_cluster
    cluster_tile #(
      .WordsPerCluster (WordsPerCluster),
      .ClusterIdx      (i),
      .NrClusters      (NrClusters)
    ) i_cluster_tile (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .tile_id_i    (tile_id_i),
      .req_valid_i  (clu_req_valid[i]),
      .req_we_i     (clu_req_we),
      .req_word_i   (clu_req_word),
      .req_wdata_i  (clu_req_wdata),
      .req_wstrb_i  (clu_req_wstrb),
      .rsp_valid_o  (clu_rsp_valid[i]),
      .rsp_slverr_o (clu_rsp_slverr[i]),
      .rsp_rdata_o  (clu_rsp_rdata[i])
    );
  end

  quadrant_resp_merge #(
    .NrClusters (NrClusters)
  ) i_quadrant_resp_merge (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .clu_rsp_valid_i  (clu_rsp_valid),
    .clu_rsp_slverr_i (clu_rsp_slverr),
    .clu_rsp_rdata_i  (clu_rsp_rdata),
    .dec_err_valid_i  (dec_err_valid),
    .req_is_write_i   (req_is_write),
    .bvalid_o         (bvalid_o),
    .bready_i         (bready_i),
    .bresp_o          (bresp_o),
    .rvalid_o         (rvalid_o),
    .rready_i         (rready_i),
    .rdata_o          (rdata_o),
    .rresp_o          (rresp_o),
    .resp_done_o      (resp_done)
  );

endmodule
